//--- hdl/visor_regs_pkg.sv
package visor_regs_pkg;

    // host register bus
    localparam int data_width = 16;
    localparam int addr_width = 4;

    // bus_ctrl is the only short register on this side
    localparam int bus_ctrl_width = 4;

    // word offsets, breakpoints first
    localparam logic [addr_width-1:0] reg_bp0 = 4'd0;
    localparam logic [addr_width-1:0] reg_bp1 = 4'd1;
    localparam logic [addr_width-1:0] reg_bp2 = 4'd2;
    localparam logic [addr_width-1:0] reg_bp3 = 4'd3;
    localparam logic [addr_width-1:0] reg_force_opcode = 4'd4;
    localparam logic [addr_width-1:0] reg_poke_data = 4'd5;
    localparam logic [addr_width-1:0] reg_bus_ctrl = 4'd6;
    localparam logic [addr_width-1:0] reg_tg_force = 4'd7;
    localparam logic [addr_width-1:0] reg_prog_addr = 4'd8;
    localparam logic [addr_width-1:0] reg_prog_data = 4'd9;

    // read-only from here up
    localparam logic [addr_width-1:0] reg_exr_shadow = 4'd10;
    localparam logic [addr_width-1:0] reg_tg_code_addr = 4'd11;
    localparam logic [addr_width-1:0] reg_peek_data = 4'd12;
    localparam logic [addr_width-1:0] reg_bp_status = 4'd13;
    localparam logic [addr_width-1:0] reg_boot_break = 4'd14;

    // bus_ctrl bits
    localparam int ctrl_forced_ready = 0;
    localparam int ctrl_tg_reset = 1;
    localparam int ctrl_divert = 2;
    localparam int ctrl_step = 3;

endpackage

//--- hdl/visor_target_pkg.sv
package visor_target_pkg;

    // code bus of the target, address and opcode alike
    localparam int code_width = 16;

    // force_exec, force_load_exr, hold_state
    localparam int debug_in_width = 3;

    localparam int debug_out_width = 7;

    // positions inside tg_debug_out
    localparam int dbg_enable_exec = 0;
    localparam int dbg_loading_exr = 1;
    localparam int dbg_program_break = 6;

endpackage

//--- hdl/visor_apb_regs.sv
`timescale 1ns/100ps

module visor_apb_regs #(
    parameter int prog_addr_width = 10,
    parameter int num_bp = 4
) (
    input  logic sysreset,
    input  logic sysclk,

    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [visor_regs_pkg::addr_width-1:0] paddr,
    input  logic [visor_regs_pkg::data_width-1:0] pwdata,
    output logic [visor_regs_pkg::data_width-1:0] prdata,
    output logic pready,
    output logic pslverr,

    input  logic [visor_regs_pkg::data_width-1:0] prog_rdata,
    input  logic [visor_regs_pkg::data_width-1:0] rom_word,
    input  logic bp_hit,
    input  logic [visor_regs_pkg::data_width-1:0] exr_shadow,
    input  logic [visor_target_pkg::code_width-1:0] tg_code_addr,
    input  logic [visor_regs_pkg::data_width-1:0] tg_peek_data,
    input  logic boot_break,

    output logic [num_bp-1:0][visor_regs_pkg::data_width-1:0] bp_addr,
    output logic bp_load,
    output logic [visor_regs_pkg::data_width-1:0] force_opcode,
    output logic [visor_regs_pkg::data_width-1:0] tg_poke_data,
    output logic ctrl_step,
    output logic ctrl_divert,
    output logic ctrl_forced_ready,
    output logic tg_reset,
    output logic [visor_target_pkg::debug_in_width-1:0] tg_debug_in,
    output logic [prog_addr_width-1:0] prog_addr,
    output logic [visor_regs_pkg::data_width-1:0] prog_wdata,
    output logic prog_we
);

    localparam int dw = visor_regs_pkg::data_width;

    logic wr_access;
    logic [num_bp-1:0] bp_wr;
    logic [visor_regs_pkg::bus_ctrl_width-1:0] bus_ctrl;

    // no wait states, a write lands at the end of the access phase
    assign pready = 1'b1;
    assign wr_access = psel && penable && pwrite;

    // everything from the shadow upwards is read-only or unmapped
    assign pslverr = wr_access && (paddr >= visor_regs_pkg::reg_exr_shadow);

    always_comb begin
        for (int i = 0; i < num_bp; i++) begin
            bp_wr[i] = wr_access &&
                       (int'(paddr) == int'(visor_regs_pkg::reg_bp0) + i);
        end
    end

    assign bp_load = |bp_wr;

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            bp_addr <= '0;
            force_opcode <= '0;
            tg_poke_data <= '0;
            bus_ctrl <= '0;
            tg_debug_in <= '0;
            prog_addr <= '0;
            prog_wdata <= '0;
            prog_we <= 1'b0;
        end else begin
            // RAM write trails the data register by one cycle
            prog_we <= wr_access && (paddr == visor_regs_pkg::reg_prog_data);
            for (int i = 0; i < num_bp; i++) begin
                if (bp_wr[i]) begin
                    bp_addr[i] <= pwdata;
                end
            end
            if (wr_access) begin
                case (paddr)
                    visor_regs_pkg::reg_force_opcode: force_opcode <= pwdata;
                    visor_regs_pkg::reg_poke_data: tg_poke_data <= pwdata;
                    visor_regs_pkg::reg_bus_ctrl:
                        bus_ctrl <= pwdata[visor_regs_pkg::bus_ctrl_width-1:0];
                    visor_regs_pkg::reg_tg_force:
                        tg_debug_in <= pwdata[visor_target_pkg::debug_in_width-1:0];
                    visor_regs_pkg::reg_prog_addr:
                        prog_addr <= pwdata[prog_addr_width-1:0];
                    visor_regs_pkg::reg_prog_data: prog_wdata <= pwdata;
                    default: ;
                endcase
            end
        end
    end

    assign ctrl_forced_ready = bus_ctrl[visor_regs_pkg::ctrl_forced_ready];
    assign ctrl_divert = bus_ctrl[visor_regs_pkg::ctrl_divert];
    assign ctrl_step = bus_ctrl[visor_regs_pkg::ctrl_step];

    // target held in reset with the system, or on host request
    assign tg_reset = sysclk || bus_ctrl[visor_regs_pkg::ctrl_tg_reset];

    always_comb begin
        case (paddr)
            visor_regs_pkg::reg_force_opcode: prdata = force_opcode;
            visor_regs_pkg::reg_poke_data: prdata = tg_poke_data;
            visor_regs_pkg::reg_bus_ctrl: prdata = dw'(bus_ctrl);
            visor_regs_pkg::reg_tg_force: prdata = dw'(tg_debug_in);
            visor_regs_pkg::reg_prog_addr: prdata = dw'(prog_addr);
            visor_regs_pkg::reg_prog_data: prdata = prog_rdata;
            visor_regs_pkg::reg_exr_shadow: prdata = exr_shadow;
            visor_regs_pkg::reg_tg_code_addr: prdata = dw'(tg_code_addr);
            visor_regs_pkg::reg_peek_data: prdata = tg_peek_data;
            visor_regs_pkg::reg_bp_status: prdata = dw'(bp_hit);
            visor_regs_pkg::reg_boot_break: prdata = dw'(boot_break);
            // the spare offset mirrors the word on the target code port
            default: prdata = (paddr > visor_regs_pkg::reg_boot_break) ? rom_word : '0;
        endcase
        for (int i = 0; i < num_bp; i++) begin
            if (int'(paddr) == int'(visor_regs_pkg::reg_bp0) + i) begin
                prdata = bp_addr[i];
            end
        end
    end

    // host side protocol
    penable_needs_psel: assert property (
        @(posedge sysreset) disable iff (sysclk)
        $rose(penable) |-> psel
    );

    paddr_held_in_access: assert property (
        @(posedge sysreset) disable iff (sysclk)
        (psel && penable) |-> $stable(paddr)
    );

endmodule

//--- hdl/visor_break_unit.sv
`timescale 1ns/100ps

module visor_break_unit #(
    parameter int prog_addr_width = 10,
    parameter int num_bp = 4
) (
    input  logic sysreset,
    input  logic sysclk,
    input  logic [visor_target_pkg::code_width-1:0] tg_code_addr,
    input  logic [visor_target_pkg::debug_out_width-1:0] tg_debug_out,
    input  logic [num_bp-1:0][visor_regs_pkg::data_width-1:0] bp_addr,
    input  logic bp_load,
    input  logic ctrl_step,
    input  logic ctrl_divert,
    input  logic [visor_regs_pkg::data_width-1:0] rom_word,
    output logic bp_hit,
    output logic [visor_regs_pkg::data_width-1:0] exr_shadow
);

    logic enable_exec;
    logic loading_exr;
    logic program_break;
    logic [num_bp-1:0] addr_eq;
    logic match_now;
    logic bp_matched;

    // the RAM window has to fit inside what the target can address
    if (prog_addr_width > visor_target_pkg::code_width) begin : g_depth_check
        $error("program RAM wider than the target code address");
    end

    assign enable_exec = tg_debug_out[visor_target_pkg::dbg_enable_exec];
    assign loading_exr = tg_debug_out[visor_target_pkg::dbg_loading_exr];
    assign program_break = tg_debug_out[visor_target_pkg::dbg_program_break];

    always_comb begin
        for (int i = 0; i < num_bp; i++) begin
            addr_eq[i] = (tg_code_addr == bp_addr[i]);
        end
    end

    assign match_now = (|addr_eq) || ctrl_step || program_break;

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            bp_matched <= 1'b0;
            bp_hit <= 1'b0;
            exr_shadow <= '0;
        end else begin
            // only words coming from RAM are worth shadowing
            if (loading_exr && !ctrl_divert) begin
                exr_shadow <= rom_word;
            end
            if (bp_load) begin
                bp_matched <= 1'b0;
                bp_hit <= 1'b0;
            end else begin
                if (match_now) begin
                    bp_matched <= 1'b1;
                end
                // wait for a plain execute cycle, so the host can later
                // take the bus and refill exr without losing a load
                if (enable_exec && (bp_matched || match_now)) begin
                    bp_hit <= 1'b1;
                end
            end
        end
    end

    // a breakpoint rewrite always wins over a pending hit
    no_hit_after_load: assert property (
        @(posedge sysreset) disable iff (sysclk)
        bp_load |=> !bp_hit
    );

endmodule

//--- hdl/visor_code_path.sv
`timescale 1ns/100ps

module visor_code_path #(
    parameter int prog_addr_width = 10
) (
    input  logic sysreset,
    input  logic sysclk,
    input  logic [prog_addr_width-1:0] prog_addr,
    input  logic [visor_regs_pkg::data_width-1:0] prog_wdata,
    input  logic prog_we,
    input  logic [visor_target_pkg::code_width-1:0] tg_code_addr,
    input  logic ctrl_divert,
    input  logic ctrl_forced_ready,
    input  logic [visor_regs_pkg::data_width-1:0] force_opcode,
    input  logic bp_hit,
    input  logic mcu_wait,
    output logic [visor_regs_pkg::data_width-1:0] prog_rdata,
    output logic [visor_regs_pkg::data_width-1:0] rom_word,
    output logic [visor_target_pkg::code_width-1:0] tg_code_in,
    output logic tg_code_ready
);

    localparam int depth = 1 << prog_addr_width;

    logic [visor_regs_pkg::data_width-1:0] mem [0:depth-1];
    logic [prog_addr_width-1:0] fetch_index;

    // upper fetch address bits alias onto the RAM
    assign fetch_index = tg_code_addr[prog_addr_width-1:0];

    // port A, host load and readback
    always_ff @(posedge sysreset) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_wdata;
        end
        prog_rdata <= mem[prog_addr];
    end

    // port B, target fetch, one clock behind the address
    always_ff @(posedge sysreset) begin
        rom_word <= mem[fetch_index];
    end

    // divert replaces both the opcode and the handshake
    assign tg_code_in = ctrl_divert ? force_opcode : rom_word;
    assign tg_code_ready = ctrl_divert ? ctrl_forced_ready : !(mcu_wait || bp_hit);

    // the load strobe comes from a reset register in the host block
    no_write_in_reset: assert property (
        @(posedge sysreset)
        sysclk |-> !prog_we
    );

endmodule

//--- hdl/visor_top.sv
`timescale 1ns/100ps

module visor_top #(
    parameter int prog_addr_width = 10,
    parameter int num_bp = 4
) (
    input  logic sysreset,
    input  logic sysclk,

    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [visor_regs_pkg::addr_width-1:0] paddr,
    input  logic [visor_regs_pkg::data_width-1:0] pwdata,
    output logic [visor_regs_pkg::data_width-1:0] prdata,
    output logic pready,
    output logic pslverr,

    input  logic [visor_target_pkg::code_width-1:0] tg_code_addr,
    output logic [visor_target_pkg::code_width-1:0] tg_code_in,
    output logic tg_code_ready,
    output logic [visor_target_pkg::debug_in_width-1:0] tg_debug_in,
    input  logic [visor_target_pkg::debug_out_width-1:0] tg_debug_out,
    output logic tg_reset,
    input  logic [visor_regs_pkg::data_width-1:0] tg_peek_data,
    output logic [visor_regs_pkg::data_width-1:0] tg_poke_data,
    input  logic mcu_wait,
    input  logic boot_break
);

    logic [num_bp-1:0][visor_regs_pkg::data_width-1:0] bp_addr;
    logic bp_load;
    logic bp_hit;
    logic ctrl_step;
    logic ctrl_divert;
    logic ctrl_forced_ready;
    logic [visor_regs_pkg::data_width-1:0] force_opcode;
    logic [visor_regs_pkg::data_width-1:0] exr_shadow;
    logic [visor_regs_pkg::data_width-1:0] rom_word;
    logic [prog_addr_width-1:0] prog_addr;
    logic [visor_regs_pkg::data_width-1:0] prog_wdata;
    logic [visor_regs_pkg::data_width-1:0] prog_rdata;
    logic prog_we;

    visor_apb_regs #(
        .prog_addr_width(prog_addr_width),
        .num_bp(num_bp)
    ) u_regs (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .prog_rdata(prog_rdata),
        .rom_word(rom_word),
        .bp_hit(bp_hit),
        .exr_shadow(exr_shadow),
        .tg_code_addr(tg_code_addr),
        .tg_peek_data(tg_peek_data),
        .boot_break(boot_break),
        .bp_addr(bp_addr),
        .bp_load(bp_load),
        .force_opcode(force_opcode),
        .tg_poke_data(tg_poke_data),
        .ctrl_step(ctrl_step),
        .ctrl_divert(ctrl_divert),
        .ctrl_forced_ready(ctrl_forced_ready),
        .tg_reset(tg_reset),
        .tg_debug_in(tg_debug_in),
        .prog_addr(prog_addr),
        .prog_wdata(prog_wdata),
        .prog_we(prog_we)
    );

    visor_break_unit #(
        .prog_addr_width(prog_addr_width),
        .num_bp(num_bp)
    ) u_break (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .tg_code_addr(tg_code_addr),
        .tg_debug_out(tg_debug_out),
        .bp_addr(bp_addr),
        .bp_load(bp_load),
        .ctrl_step(ctrl_step),
        .ctrl_divert(ctrl_divert),
        .rom_word(rom_word),
        .bp_hit(bp_hit),
        .exr_shadow(exr_shadow)
    );

    visor_code_path #(
        .prog_addr_width(prog_addr_width)
    ) u_code (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .prog_addr(prog_addr),
        .prog_wdata(prog_wdata),
        .prog_we(prog_we),
        .tg_code_addr(tg_code_addr),
        .ctrl_divert(ctrl_divert),
        .ctrl_forced_ready(ctrl_forced_ready),
        .force_opcode(force_opcode),
        .bp_hit(bp_hit),
        .mcu_wait(mcu_wait),
        .prog_rdata(prog_rdata),
        .rom_word(rom_word),
        .tg_code_in(tg_code_in),
        .tg_code_ready(tg_code_ready)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period = 20,
    parameter int reset_cycles = 16
) (
    output logic sysreset,
    output logic sysclk
);

    // clock runs on sysreset, the active high reset on sysclk
    initial begin
        sysreset = 1'b0;
        forever begin
            #(period / 2);
            sysreset = ~sysreset;
        end
    end

    initial begin
        sysclk = 1'b1;
        repeat (reset_cycles) @(posedge sysreset);
        #2;
        sysclk = 1'b0;
    end

endmodule

//--- test/tb_visor_checker.sv
`timescale 1ns/100ps

module tb_visor_checker (
    input logic sysreset,
    input logic sysclk,
    input logic [visor_regs_pkg::data_width-1:0] prdata,
    input logic pready,
    input logic pslverr,
    input logic [visor_target_pkg::code_width-1:0] tg_code_in,
    input logic tg_code_ready,
    input logic tg_reset,
    input logic [visor_target_pkg::debug_in_width-1:0] tg_debug_in,
    input logic [visor_regs_pkg::data_width-1:0] tg_poke_data
);

    localparam int dw = visor_regs_pkg::data_width;

    int watch_errors = 0;
    int compare_errors = 0;
    int check_total = 0;
    int test_count = 0;
    int mark_checks = 0;
    int mark_errors = 0;

    function automatic int error_total();
        return watch_errors + compare_errors;
    endfunction

    // mid-cycle watch, inputs only move 2 ns after the rising edge
    always @(negedge sysreset) begin
        if (pready !== 1'b1) begin
            $display("pready went low, the port inserted a wait state");
            watch_errors++;
        end
        if (sysclk && tg_reset !== 1'b1) begin
            $display("tg_reset was released while the system reset was still high");
            watch_errors++;
        end
    end

    task automatic compare(input string name, input logic [dw-1:0] expected);
        logic [dw-1:0] actual;
        logic known;
        known = 1'b1;
        actual = '0;
        if (name == "prdata") begin
            actual = prdata;
        end else if (name == "pslverr") begin
            actual = dw'(pslverr);
        end else if (name == "tg_code_in") begin
            actual = dw'(tg_code_in);
        end else if (name == "tg_code_ready") begin
            actual = dw'(tg_code_ready);
        end else if (name == "tg_reset") begin
            actual = dw'(tg_reset);
        end else if (name == "tg_debug_in") begin
            actual = dw'(tg_debug_in);
        end else if (name == "tg_poke_data") begin
            actual = tg_poke_data;
        end else begin
            known = 1'b0;
        end
        check_total++;
        if (!known) begin
            $display("compare asked for %0s, which this checker does not watch", name);
            compare_errors++;
        end else if (actual !== expected) begin
            $display("Error %0s: expected 0x%h, got 0x%h", name, expected, actual);
            compare_errors++;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %0s: %0d checks, %0d errors", test_count, name,
                 check_total - mark_checks, error_total() - mark_errors);
        mark_checks = check_total;
        mark_errors = error_total();
    endtask

    task automatic print_totals();
        $display("totals: %0d tests, %0d checks, %0d errors",
                 test_count, check_total, error_total());
    endtask

endmodule

//--- test/tb_visor.sv
`timescale 1ns/100ps

module tb_visor;

    localparam int prog_addr_width = 10;
    localparam int num_bp = 4;
    localparam int clk_period = 20;
    localparam int num_loads = 16;

    localparam int dw = visor_regs_pkg::data_width;
    localparam int aw = visor_regs_pkg::addr_width;
    localparam int cw = visor_target_pkg::code_width;
    localparam int off_poke = int'(visor_regs_pkg::reg_poke_data);
    localparam int off_bus_ctrl = int'(visor_regs_pkg::reg_bus_ctrl);
    localparam int off_tg_force = int'(visor_regs_pkg::reg_tg_force);
    localparam int off_prog_addr = int'(visor_regs_pkg::reg_prog_addr);
    localparam int off_prog_data = int'(visor_regs_pkg::reg_prog_data);
    localparam int off_first_ro = int'(visor_regs_pkg::reg_exr_shadow);

    // cycle budget per test, generous upper bounds
    localparam int run_cycles = 16 + 330 + 170 + 70 + 80 + 110;

    logic sysreset;
    logic sysclk;
    logic psel;
    logic penable;
    logic pwrite;
    logic [aw-1:0] paddr;
    logic [dw-1:0] pwdata;
    logic [dw-1:0] prdata;
    logic pready;
    logic pslverr;
    logic [cw-1:0] tg_code_addr;
    logic [cw-1:0] tg_code_in;
    logic tg_code_ready;
    logic [visor_target_pkg::debug_in_width-1:0] tg_debug_in;
    logic [visor_target_pkg::debug_out_width-1:0] tg_debug_out;
    logic tg_reset;
    logic [dw-1:0] tg_peek_data;
    logic [dw-1:0] tg_poke_data;
    logic mcu_wait;
    logic boot_break;

    integer seed;
    logic [dw-1:0] reg_model [0:9];
    logic [dw-1:0] ram_model [0:(1 << prog_addr_width)-1];
    logic [prog_addr_width-1:0] load_addr [0:num_loads-1];

    tb_clock_gen #(
        .period(clk_period),
        .reset_cycles(16)
    ) u_clk (
        .sysreset(sysreset),
        .sysclk(sysclk)
    );

    visor_top #(
        .prog_addr_width(prog_addr_width),
        .num_bp(num_bp)
    ) u_dut (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .tg_code_addr(tg_code_addr),
        .tg_code_in(tg_code_in),
        .tg_code_ready(tg_code_ready),
        .tg_debug_in(tg_debug_in),
        .tg_debug_out(tg_debug_out),
        .tg_reset(tg_reset),
        .tg_peek_data(tg_peek_data),
        .tg_poke_data(tg_poke_data),
        .mcu_wait(mcu_wait),
        .boot_break(boot_break)
    );

    tb_visor_checker u_chk (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .tg_code_in(tg_code_in),
        .tg_code_ready(tg_code_ready),
        .tg_reset(tg_reset),
        .tg_debug_in(tg_debug_in),
        .tg_poke_data(tg_poke_data)
    );

    function automatic logic [dw-1:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        return r[dw-1:0];
    endfunction

    // register widths as the map defines them
    function automatic logic [dw-1:0] reg_mask(input int offset);
        if (offset == off_bus_ctrl) begin
            return dw'((1 << visor_regs_pkg::bus_ctrl_width) - 1);
        end else if (offset == off_tg_force) begin
            return dw'((1 << visor_target_pkg::debug_in_width) - 1);
        end else if (offset == off_prog_addr) begin
            return dw'((1 << prog_addr_width) - 1);
        end
        return '1;
    endfunction

    // the data register reads back the RAM word at the program address
    function automatic logic [dw-1:0] expected_read(input int offset);
        logic [prog_addr_width-1:0] idx;
        idx = reg_model[off_prog_addr][prog_addr_width-1:0];
        if (offset == off_prog_data) begin
            return ram_model[idx];
        end
        return reg_model[offset];
    endfunction

    task automatic next_cycle();
        @(posedge sysreset);
        #2;
    endtask

    task automatic sample_point();
        #15;
    endtask

    task automatic reg_write(input int offset, input logic [dw-1:0] data);
        logic bad;
        logic [prog_addr_width-1:0] idx;
        bad = offset >= off_first_ro;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = aw'(offset);
        pwdata = data;
        next_cycle();
        penable = 1'b1;
        sample_point();
        u_chk.compare("pslverr", dw'(bad));
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        if (!bad) begin
            reg_model[offset] = data & reg_mask(offset);
            if (offset == off_prog_data) begin
                idx = reg_model[off_prog_addr][prog_addr_width-1:0];
                ram_model[idx] = data;
            end
        end
    endtask

    task automatic reg_read(input int offset, input logic [dw-1:0] expected);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = aw'(offset);
        next_cycle();
        penable = 1'b1;
        sample_point();
        u_chk.compare("prdata", expected);
        u_chk.compare("pslverr", '0);
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_back_writable();
        for (int off = 0; off <= off_prog_data; off++) begin
            reg_read(off, expected_read(off));
        end
    endtask

    task automatic exec_pulse();
        tg_debug_out[visor_target_pkg::dbg_enable_exec] = 1'b1;
        next_cycle();
        tg_debug_out[visor_target_pkg::dbg_enable_exec] = 1'b0;
    endtask

    task automatic expect_hit(input logic hit);
        sample_point();
        u_chk.compare("tg_code_ready", dw'(!hit));
        next_cycle();
        reg_read(int'(visor_regs_pkg::reg_bp_status), dw'(hit));
    endtask

    task automatic test_registers();
        sample_point();
        u_chk.compare("tg_reset", '0);
        u_chk.compare("tg_debug_in", '0);
        next_cycle();
        // RAM contents are unknown until loaded, so skip the data register
        for (int off = 0; off < off_prog_data; off++) begin
            reg_read(off, expected_read(off));
        end
        for (int pass = 0; pass < 4; pass++) begin
            for (int off = 0; off <= off_prog_data; off++) begin
                reg_write(off, rand16());
            end
            sample_point();
            u_chk.compare("tg_poke_data", reg_model[off_poke]);
            next_cycle();
            read_back_writable();
            for (int off = off_first_ro; off < (1 << aw); off++) begin
                reg_write(off, rand16());
            end
            read_back_writable();
        end
        reg_write(off_bus_ctrl, '0);
        reg_write(off_tg_force, '0);
    endtask

    task automatic test_program();
        logic [dw-1:0] r;
        for (int i = 0; i < num_loads; i++) begin
            r = rand16();
            load_addr[i] = r[prog_addr_width-1:0];
            reg_write(off_prog_addr, dw'(load_addr[i]));
            reg_write(off_prog_data, rand16());
        end
        for (int i = 0; i < num_loads; i++) begin
            reg_write(off_prog_addr, dw'(load_addr[i]));
            reg_read(off_prog_data, ram_model[load_addr[i]]);
        end
        // port B answers one clock after the address
        for (int i = 0; i < num_loads; i++) begin
            tg_code_addr = cw'(load_addr[i]);
            next_cycle();
            sample_point();
            u_chk.compare("tg_code_in", ram_model[load_addr[i]]);
            next_cycle();
        end
    endtask

    task automatic test_divert();
        logic [dw-1:0] opcode;
        logic [dw-1:0] ctrl;
        logic [dw-1:0] force_bits;
        for (int n = 0; n < 8; n++) begin
            opcode = rand16();
            ctrl = rand16() & dw'((1 << visor_regs_pkg::ctrl_forced_ready) |
                                  (1 << visor_regs_pkg::ctrl_tg_reset));
            ctrl = ctrl | dw'(1 << visor_regs_pkg::ctrl_divert);
            force_bits = rand16();
            // a diverted bus ignores the target's own wait
            mcu_wait = n[0];
            reg_write(int'(visor_regs_pkg::reg_force_opcode), opcode);
            reg_write(off_bus_ctrl, ctrl);
            reg_write(off_tg_force, force_bits);
            sample_point();
            u_chk.compare("tg_code_in", opcode);
            u_chk.compare("tg_code_ready", dw'(ctrl[visor_regs_pkg::ctrl_forced_ready]));
            u_chk.compare("tg_reset", dw'(ctrl[visor_regs_pkg::ctrl_tg_reset]));
            u_chk.compare("tg_debug_in", force_bits & reg_mask(off_tg_force));
            next_cycle();
        end
        reg_write(off_bus_ctrl, '0);
        reg_write(off_tg_force, '0);
        mcu_wait = 1'b1;
        sample_point();
        u_chk.compare("tg_reset", '0);
        u_chk.compare("tg_debug_in", '0);
        u_chk.compare("tg_code_ready", '0);
        next_cycle();
        mcu_wait = 1'b0;
        sample_point();
        u_chk.compare("tg_code_ready", dw'(1'b1));
        next_cycle();
    endtask

    task automatic test_breakpoints();
        logic [dw-1:0] new_bp [0:num_bp-1];
        logic [dw-1:0] miss;
        logic clash;
        int k;
        for (int i = 0; i < num_bp; i++) begin
            new_bp[i] = rand16();
        end
        clash = 1'b1;
        while (clash) begin
            miss = rand16();
            clash = 1'b0;
            for (int i = 0; i < num_bp; i++) begin
                if (new_bp[i] == miss) begin
                    clash = 1'b1;
                end
            end
        end
        // park the fetch address first, the last write clears any old match
        tg_code_addr = miss;
        for (int i = 0; i < num_bp; i++) begin
            reg_write(i, new_bp[i]);
        end
        repeat (3) exec_pulse();
        expect_hit(1'b0);

        k = int'(rand16()) % num_bp;
        tg_code_addr = reg_model[k];
        next_cycle();
        tg_code_addr = miss;
        exec_pulse();
        expect_hit(1'b1);
        reg_write(k, reg_model[k]);
        expect_hit(1'b0);

        // single step
        reg_write(off_bus_ctrl, dw'(1 << visor_regs_pkg::ctrl_step));
        exec_pulse();
        expect_hit(1'b1);
        reg_write(off_bus_ctrl, '0);
        reg_write(0, reg_model[0]);
        expect_hit(1'b0);

        // break request raised by the target itself
        tg_debug_out[visor_target_pkg::dbg_program_break] = 1'b1;
        next_cycle();
        tg_debug_out[visor_target_pkg::dbg_program_break] = 1'b0;
        exec_pulse();
        expect_hit(1'b1);
        reg_write(num_bp - 1, reg_model[num_bp - 1]);
        expect_hit(1'b0);
    endtask

    task automatic test_status();
        logic [dw-1:0] code_addr;
        logic [dw-1:0] peek;
        logic [dw-1:0] r;
        logic [prog_addr_width-1:0] idx;
        for (int n = 0; n < 8; n++) begin
            code_addr = rand16();
            peek = rand16();
            r = rand16();
            tg_code_addr = code_addr;
            tg_peek_data = peek;
            boot_break = r[0];
            reg_read(int'(visor_regs_pkg::reg_tg_code_addr), code_addr);
            reg_read(int'(visor_regs_pkg::reg_peek_data), peek);
            reg_read(int'(visor_regs_pkg::reg_boot_break), dw'(r[0]));
        end
        // shadow of an execute-register load from RAM
        for (int n = 0; n < 6; n++) begin
            idx = load_addr[int'(rand16()) % num_loads];
            tg_code_addr = cw'(idx);
            next_cycle();
            next_cycle();
            tg_debug_out[visor_target_pkg::dbg_loading_exr] = 1'b1;
            next_cycle();
            tg_debug_out[visor_target_pkg::dbg_loading_exr] = 1'b0;
            reg_read(int'(visor_regs_pkg::reg_exr_shadow), ram_model[idx]);
        end
    endtask

    initial begin
        seed = 32'h0225_8716;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        tg_code_addr = '0;
        tg_debug_out = '0;
        tg_peek_data = '0;
        mcu_wait = 1'b0;
        boot_break = 1'b0;
        for (int i = 0; i <= off_prog_data; i++) begin
            reg_model[i] = '0;
        end
        @(negedge sysclk);
        next_cycle();
        test_registers();
        u_chk.end_test("register access");
        test_program();
        u_chk.end_test("program load and fetch");
        test_divert();
        u_chk.end_test("code-bus divert");
        test_breakpoints();
        u_chk.end_test("breakpoints");
        test_status();
        u_chk.end_test("status and shadow");
        u_chk.print_totals();
        if (u_chk.error_total() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(4 * run_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d ns",
                 4 * run_cycles * clk_period);
        $display("Something failed");
        $finish;
    end

endmodule

//--- build.f
hdl/visor_regs_pkg.sv
hdl/visor_target_pkg.sv
hdl/visor_apb_regs.sv
hdl/visor_break_unit.sv
hdl/visor_code_path.sv
hdl/visor_top.sv
test/tb_clock_gen.sv
test/tb_visor_checker.sv
test/tb_visor.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the visor testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_visor \
    -o tb_visor > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see $build_log"
    exit 1
fi

./obj_dir/tb_visor > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $sim_log"
    exit 1
fi

if grep -qx "Everything OK" "$sim_log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $sim_log"
    exit 1
fi
